// ==== verilog/aznable_consts.svh ====
`ifndef AZNABLE_CONSTS_SVH
`define AZNABLE_CONSTS_SVH

// Processor bus widths
`define AZ_ADDR_W 16
`define AZ_DATA_W 8

// Memory sizes as address widths
`define AZ_WKRAM_AW 14
`define AZ_COLRAM_AW 5

// Millisecond timer, 24 MHz clock
`define AZ_TIMER_DIV 24000
`define AZ_TIMER_W 16

// High address byte of each memory mapped page
`define AZ_JOY_PAGE 8'h81
`define AZ_ANL_PAGE 8'h82
`define AZ_ANR_PAGE 8'h83
`define AZ_PADDLE_PAGE 8'h84
`define AZ_SPIN_PAGE 8'h85
`define AZ_KEY_PAGE 8'h86
`define AZ_MOUSE_PAGE 8'h87
`define AZ_TSTAMP_PAGE 8'h88
`define AZ_TIMER_PAGE 8'h89
`define AZ_COLRAM_PAGE 8'hB4

// Pause register sits at 8A30h to 8A3Fh
`define AZ_PAUSE_TAG 12'h8A3

`endif

// ==== verilog/bus_pkg.sv ====
`default_nettype none

`include "aznable_consts.svh"

package bus_pkg;

	// One processor cycle as seen by the bus
	typedef struct packed {
		logic [`AZ_ADDR_W-1:0] addr;
		logic [`AZ_DATA_W-1:0] wdata;
		logic                  wr;
	} cpu_bus_t;

	// Source of the read byte
	typedef enum logic [3:0] {
		NONE, WKRAM, COLRAM, JOY, ANL, ANR, PADDLE, SPIN, KEY, MOUSE, TSTAMP, TIMER
	} region_e;

	typedef struct packed {
		logic wkram;
		logic colram;
		logic timer_clear;
		logic pause_set;
	} wr_strobe_t;

	// Region plus byte offset into that region
	typedef struct packed {
		region_e    region;
		logic [4:0] offset;
	} rd_sel_t;

endpackage

`default_nettype wire

// ==== verilog/io_pkg.sv ====
`default_nettype none

`include "aznable_consts.svh"

package io_pkg;

	typedef logic [`AZ_DATA_W-1:0] byte_t;

	// Host side inputs, field widths follow the host framework
	typedef struct packed {
		// 6 devices of 32 buttons
		logic [191:0] joystick;
		// 6 devices, Y in [15:8], X in [7:0]
		logic [95:0]  analog_l;
		logic [95:0]  analog_r;
		logic [47:0]  paddle;
		// Bit 8 of each device toggles per update
		logic [95:0]  spinner;
		// [8] extended, [9] pressed, [10] toggle
		logic [10:0]  ps2_key;
		logic [47:0]  ps2_mouse;
		// Seconds count plus change toggle in bit 32
		logic [32:0]  timestamp;
	} host_inputs_t;

endpackage

`default_nettype wire

// ==== verilog/addr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aznable_consts.svh"

module addr_decoder (
	input  wire logic               clk_24,
	input  wire logic               rst_n,
	input  wire bus_pkg::cpu_bus_t  bus,
	input  wire logic               pause,
	output bus_pkg::rd_sel_t        sel,
	output bus_pkg::wr_strobe_t     wr,
	output logic                    pause_out
);
	import bus_pkg::*;

	region_e region;
	logic    pause_latch;

	// Work RAM takes the whole top quarter and the rest decodes by page
	always_comb
	begin
		region = NONE;
		if (bus.addr[15:14] == 2'b11)
			region = WKRAM;
		else
		begin
			case (bus.addr[15:8])
				`AZ_JOY_PAGE:    region = JOY;
				`AZ_ANL_PAGE:    region = ANL;
				`AZ_ANR_PAGE:    region = ANR;
				`AZ_PADDLE_PAGE: region = PADDLE;
				`AZ_SPIN_PAGE:   region = SPIN;
				`AZ_KEY_PAGE:    region = KEY;
				`AZ_MOUSE_PAGE:  region = MOUSE;
				`AZ_TSTAMP_PAGE: region = TSTAMP;
				`AZ_TIMER_PAGE:  region = TIMER;
				`AZ_COLRAM_PAGE: region = COLRAM;
				default:         region = NONE;
			endcase
		end
	end

	assign sel.region = region;
	assign sel.offset = bus.addr[4:0];

	assign wr.wkram       = bus.wr && (region == WKRAM);
	assign wr.colram      = bus.wr && (region == COLRAM);
	assign wr.timer_clear = bus.wr && (region == TIMER);
	assign wr.pause_set   = bus.wr && (bus.addr[15:4] == `AZ_PAUSE_TAG);

	// Host pause releases the latch, and wins over a write in the same cycle
	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
			pause_latch <= 1'b0;
		else if (pause)
			pause_latch <= 1'b0;
		else if (wr.pause_set)
			pause_latch <= 1'b1;
	end

	assign pause_out = pause || pause_latch;

	a_one_strobe: assert property (@(posedge clk_24) disable iff (!rst_n) $onehot0(wr));

endmodule

`default_nettype wire

// ==== verilog/sync_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_ram #(
	parameter int  AW = 8,
	parameter type data_t = logic
) (
	input  wire logic          clk_24,
	input  wire logic [AW-1:0] addr,
	input  wire logic          we,
	input  wire data_t         wdata,
	output data_t              rdata
);

	data_t mem [2**AW];

	// Write-first port, a write shows its own data on the same edge
	always_ff @(posedge clk_24)
	begin
		if (we)
		begin
			mem[addr] <= wdata;
			rdata <= wdata;
		end
		else
			rdata <= mem[addr];
	end

	a_addr_known: assert property (@(posedge clk_24) we |-> !$isunknown(addr));

endmodule

`default_nettype wire

// ==== verilog/ms_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aznable_consts.svh"

module ms_timer (
	input  wire logic                   clk_24,
	input  wire logic                   rst_n,
	input  wire logic                   clear,
	output logic [`AZ_TIMER_W-1:0]      count
);
	localparam int PRE_W = $clog2(`AZ_TIMER_DIV);

	logic [PRE_W-1:0] prescale;

	// Prescaler divides the clock down to one tick per millisecond
	always_ff @(posedge clk_24)
	begin
		if (!rst_n || clear)
		begin
			prescale <= '0;
			count <= '0;
		end
		else if (prescale == PRE_W'(`AZ_TIMER_DIV - 1))
		begin
			prescale <= '0;
			count <= count + 1'b1;
		end
		else
			prescale <= prescale + 1'b1;
	end

	// Count wraps at 2^16 through the equality width
	a_count_step: assert property (@(posedge clk_24) disable iff (!rst_n)
		$past(rst_n) && !$past(clear) |->
			(count == $past(count)) || (count == $past(count) + 1'b1));

endmodule

`default_nettype wire

// ==== verilog/read_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aznable_consts.svh"

module read_mux (
	input  wire logic                      clk_24,
	input  wire logic                      rst_n,
	input  wire bus_pkg::rd_sel_t          sel,
	input  wire io_pkg::host_inputs_t      inputs,
	input  wire logic [`AZ_TIMER_W-1:0]    timer,
	input  wire io_pkg::byte_t             wkram_q,
	input  wire logic                      colram_q,
	output io_pkg::byte_t                  rd_data
);
	import bus_pkg::*;
	import io_pkg::*;

	// Fields padded with zeros up to the reach of their offset bits
	logic [255:0] joy_w;
	logic [127:0] anl_w;
	logic [127:0] anr_w;
	logic [127:0] spin_w;
	logic [63:0]  paddle_w;
	logic [63:0]  mouse_w;
	logic [63:0]  tstamp_w;
	logic [15:0]  key_w;

	byte_t   in_byte;
	byte_t   in_byte_q;
	rd_sel_t sel_q;

	assign joy_w    = 256'(inputs.joystick);
	assign anl_w    = 128'(inputs.analog_l);
	assign anr_w    = 128'(inputs.analog_r);
	assign spin_w   = 128'(inputs.spinner);
	assign paddle_w = 64'(inputs.paddle);
	assign mouse_w  = 64'(inputs.ps2_mouse);
	assign tstamp_w = 64'(inputs.timestamp);
	assign key_w    = 16'(inputs.ps2_key);

	always_comb
	begin
		case (sel.region)
			JOY:     in_byte = joy_w[{sel.offset, 3'd0} +: 8];
			ANL:     in_byte = anl_w[{sel.offset[3:0], 3'd0} +: 8];
			ANR:     in_byte = anr_w[{sel.offset[3:0], 3'd0} +: 8];
			SPIN:    in_byte = spin_w[{sel.offset[3:0], 3'd0} +: 8];
			PADDLE:  in_byte = paddle_w[{sel.offset[2:0], 3'd0} +: 8];
			MOUSE:   in_byte = mouse_w[{sel.offset[2:0], 3'd0} +: 8];
			TSTAMP:  in_byte = tstamp_w[{sel.offset[2:0], 3'd0} +: 8];
			KEY:     in_byte = key_w[{sel.offset[0], 3'd0} +: 8];
			TIMER:   in_byte = timer[{sel.offset[0], 3'd0} +: 8];
			default: in_byte = '0;
		endcase
	end

	// Registered to line up with the RAM read latency
	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
			sel_q <= '{region: NONE, offset: '0};
		else
			sel_q <= sel;
		in_byte_q <= in_byte;
	end

	always_comb
	begin
		case (sel_q.region)
			NONE:    rd_data = '0;
			WKRAM:   rd_data = wkram_q;
			COLRAM:  rd_data = {`AZ_DATA_W{colram_q}};
			default: rd_data = in_byte_q;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/aznable_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aznable_consts.svh"

module aznable_bus (
	input  wire logic                  clk_24,
	input  wire logic                  rst_n,
	input  wire bus_pkg::cpu_bus_t     bus,
	input  wire io_pkg::host_inputs_t  inputs,
	input  wire logic                  pause,
	output io_pkg::byte_t              rd_data,
	output logic                       pause_out
);
	import bus_pkg::*;
	import io_pkg::*;

	wr_strobe_t              wr;
	rd_sel_t                 sel;
	byte_t                   wkram_q;
	logic                    colram_q;
	logic [`AZ_TIMER_W-1:0]  timer_count;

	addr_decoder decoder (
		.clk_24    (clk_24),
		.rst_n     (rst_n),
		.bus       (bus),
		.pause     (pause),
		.sel       (sel),
		.wr        (wr),
		.pause_out (pause_out)
	);

	// Work RAM at C000h to FFFFh
	sync_ram #(.AW(`AZ_WKRAM_AW), .data_t(byte_t)) wkram (
		.clk_24 (clk_24),
		.addr   (bus.addr[`AZ_WKRAM_AW-1:0]),
		.we     (wr.wkram),
		.wdata  (bus.wdata),
		.rdata  (wkram_q)
	);

	// Sprite collision flags, one bit per entry
	sync_ram #(.AW(`AZ_COLRAM_AW), .data_t(logic)) colram (
		.clk_24 (clk_24),
		.addr   (bus.addr[`AZ_COLRAM_AW-1:0]),
		.we     (wr.colram),
		.wdata  (bus.wdata[0]),
		.rdata  (colram_q)
	);

	ms_timer timer (
		.clk_24 (clk_24),
		.rst_n  (rst_n),
		.clear  (wr.timer_clear),
		.count  (timer_count)
	);

	read_mux mux (
		.clk_24   (clk_24),
		.rst_n    (rst_n),
		.sel      (sel),
		.inputs   (inputs),
		.timer    (timer_count),
		.wkram_q  (wkram_q),
		.colram_q (colram_q),
		.rd_data  (rd_data)
	);

endmodule

`default_nettype wire

// ==== tb/tb_aznable_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aznable_consts.svh"

module tb_aznable_bus;
	import bus_pkg::*;
	import io_pkg::*;

	localparam int TIMEOUT_CYCLES = 100000;
	localparam logic [7:0] IN_PAGES [8] = '{`AZ_JOY_PAGE, `AZ_ANL_PAGE, `AZ_ANR_PAGE,
		`AZ_PADDLE_PAGE, `AZ_SPIN_PAGE, `AZ_KEY_PAGE, `AZ_MOUSE_PAGE, `AZ_TSTAMP_PAGE};
	localparam logic [7:0] FREE_PAGES [6] = '{8'h80, 8'h8A, 8'h90, 8'hA7, 8'hB3, 8'hBF};

	logic         clk_24;
	logic         rst_n;
	cpu_bus_t     bus;
	host_inputs_t inputs;
	logic         pause;
	byte_t        rd_data;
	logic         pause_out;

	// Reference model state
	byte_t        wk_model [2**`AZ_WKRAM_AW];
	logic         col_model [2**`AZ_COLRAM_AW];
	logic         pause_model;
	int           t_elapsed;
	byte_t        exp_rd;
	logic         exp_timer;
	logic [15:0]  exp_tcount;
	logic         exp_toff;
	int           cycle_count;
	logic [15:0]  wk_addrs [$];

	aznable_bus dut0 (
		.clk_24    (clk_24),
		.rst_n     (rst_n),
		.bus       (bus),
		.inputs    (inputs),
		.pause     (pause),
		.rd_data   (rd_data),
		.pause_out (pause_out)
	);

	initial clk_24 = 1'b0;
	always #5 clk_24 = ~clk_24;

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1);
	endtask

	// Byte n of a field, zero past the field's end
	function automatic byte_t field_byte(input logic [255:0] field, input int width, input int n);
		byte_t b;
		b = '0;
		for (int i = 0; i < 8; i++)
			if (8 * n + i < width)
				b[i] = field[8 * n + i];
		return b;
	endfunction

	function automatic byte_t predict_byte(input cpu_bus_t b);
		int n;
		n = int'(b.addr[4:0]);
		if (b.addr[15:14] == 2'b11)
			return b.wr ? b.wdata : wk_model[b.addr[13:0]];
		case (b.addr[15:8])
			`AZ_JOY_PAGE:    return field_byte(256'(inputs.joystick), 192, n);
			`AZ_ANL_PAGE:    return field_byte(256'(inputs.analog_l), 96, n % 16);
			`AZ_ANR_PAGE:    return field_byte(256'(inputs.analog_r), 96, n % 16);
			`AZ_SPIN_PAGE:   return field_byte(256'(inputs.spinner), 96, n % 16);
			`AZ_PADDLE_PAGE: return field_byte(256'(inputs.paddle), 48, n % 8);
			`AZ_MOUSE_PAGE:  return field_byte(256'(inputs.ps2_mouse), 48, n % 8);
			`AZ_TSTAMP_PAGE: return field_byte(256'(inputs.timestamp), 33, n % 8);
			`AZ_KEY_PAGE:    return field_byte(256'(inputs.ps2_key), 11, n % 2);
			`AZ_TIMER_PAGE:  return field_byte(256'(t_elapsed / `AZ_TIMER_DIV), 16, n % 2);
			`AZ_COLRAM_PAGE: return {8{b.wr ? b.wdata[0] : col_model[b.addr[4:0]]}};
			default:         return '0;
		endcase
	endfunction

	// Timer reads may be one millisecond off either way
	function automatic logic rd_match(input byte_t got, input byte_t want, input logic is_timer,
		input logic [15:0] tcount, input logic toff);
		logic [15:0] below;
		logic [15:0] above;
		below = tcount - 16'd1;
		above = tcount + 16'd1;
		if (!is_timer)
			return got === want;
		return (got === want) || (got === (toff ? below[15:8] : below[7:0]))
			|| (got === (toff ? above[15:8] : above[7:0]));
	endfunction

	always @(posedge clk_24)
	begin
		if (!rst_n)
		begin
			exp_rd <= '0;
			exp_timer <= 1'b0;
			pause_model <= 1'b0;
			t_elapsed <= 0;
		end
		else
		begin
			exp_rd <= predict_byte(bus);
			exp_timer <= (bus.addr[15:8] == `AZ_TIMER_PAGE);
			exp_tcount <= 16'(t_elapsed / `AZ_TIMER_DIV);
			exp_toff <= bus.addr[0];
			if (bus.wr && bus.addr[15:14] == 2'b11)
				wk_model[bus.addr[13:0]] <= bus.wdata;
			if (bus.wr && bus.addr[15:8] == `AZ_COLRAM_PAGE)
				col_model[bus.addr[4:0]] <= bus.wdata[0];
			if (bus.wr && bus.addr[15:8] == `AZ_TIMER_PAGE)
				t_elapsed <= 0;
			else
				t_elapsed <= t_elapsed + 1;
			if (pause)
				pause_model <= 1'b0;
			else if (bus.wr && bus.addr[15:4] == `AZ_PAUSE_TAG)
				pause_model <= 1'b1;
		end
	end

	a_rd_data: assert property (@(posedge clk_24) disable iff (!rst_n)
		rd_match(rd_data, exp_rd, exp_timer, exp_tcount, exp_toff))
		else stop_on_error($sformatf("ERROR %0t rd_data got %02h expected %02h",
			$time, $sampled(rd_data), $sampled(exp_rd)));

	a_pause_out: assert property (@(posedge clk_24) disable iff (!rst_n)
		pause_out === (pause || pause_model))
		else stop_on_error($sformatf("ERROR %0t pause_out got %b expected %b",
			$time, $sampled(pause_out), $sampled(pause || pause_model)));

	a_pause_rise: assert property (@(posedge clk_24) disable iff (!rst_n)
		bus.wr && bus.addr[15:4] == `AZ_PAUSE_TAG && !pause |=> pause_out)
		else stop_on_error("Pause write did not raise pause_out on the next cycle");

	always @(posedge clk_24)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES)
			stop_on_error("Timeout, the test sequence did not finish in time");
	end

	task automatic drive_cycle(input logic [15:0] addr, input byte_t data, input logic wr);
		bus = '{addr: addr, wdata: data, wr: wr};
		@(posedge clk_24);
		#1;
	endtask

	task automatic write_byte(input logic [15:0] addr, input byte_t data);
		drive_cycle(addr, data, 1'b1);
	endtask

	task automatic read_byte(input logic [15:0] addr);
		drive_cycle(addr, 8'($urandom), 1'b0);
	endtask

	task automatic idle_cycles(input int n);
		bus = '{addr: 16'h0000, wdata: 8'h00, wr: 1'b0};
		repeat (n) @(posedge clk_24);
		#1;
	endtask

	task automatic randomize_inputs();
		logic [639:0] raw;
		for (int i = 0; i < 20; i++)
			raw[i * 32 +: 32] = $urandom;
		inputs = raw[619:0];
	endtask

	initial
	begin
		logic [15:0] addr;
		void'($urandom(32'hd54ca5cd));
		cycle_count = 0;
		rst_n = 1'b0;
		pause = 1'b0;
		inputs = '0;
		bus = '{addr: 16'h0000, wdata: 8'h00, wr: 1'b0};
		repeat (16) @(posedge clk_24);
		#1;
		rst_n = 1'b1;
		idle_cycles(2);

		// Work RAM, some reads right behind their write
		for (int i = 0; i < 200; i++)
		begin
			addr = {2'b11, 14'($urandom)};
			wk_addrs.push_back(addr);
			write_byte(addr, 8'($urandom));
			if (i % 4 == 0)
				read_byte(addr);
		end
		foreach (wk_addrs[i])
			read_byte(wk_addrs[i]);

		// Collision RAM, low byte aliases modulo 32
		for (int i = 0; i < 32; i++)
			write_byte({`AZ_COLRAM_PAGE, 3'($urandom), 5'(i)}, 8'($urandom));
		for (int i = 0; i < 64; i++)
			read_byte({`AZ_COLRAM_PAGE, 8'($urandom)});
		write_byte({`AZ_COLRAM_PAGE, 8'hE3}, 8'h01);
		read_byte({`AZ_COLRAM_PAGE, 8'h03});

		randomize_inputs();
		for (int p = 0; p < 8; p++)
			for (int off = 0; off < 32; off++)
				read_byte({IN_PAGES[p], 3'($urandom), 5'(off)});

		for (int i = 0; i < 64; i++)
			read_byte({1'b0, 15'($urandom)});
		for (int p = 0; p < 6; p++)
			for (int i = 0; i < 8; i++)
				read_byte({FREE_PAGES[p], 8'($urandom)});

		write_byte({`AZ_TIMER_PAGE, 8'h00}, 8'h5A);
		for (int ms = 1; ms <= 3; ms++)
		begin
			idle_cycles(`AZ_TIMER_DIV);
			read_byte({`AZ_TIMER_PAGE, 8'h00});
			read_byte({`AZ_TIMER_PAGE, 8'h01});
		end

		// Pause set, hold, release, then clear winning over set
		write_byte(16'h8A30, 8'h00);
		idle_cycles(5);
		pause = 1'b1;
		idle_cycles(1);
		pause = 1'b0;
		idle_cycles(3);
		pause = 1'b1;
		write_byte(16'h8A35, 8'h00);
		pause = 1'b0;
		idle_cycles(4);

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+verilog
verilog/bus_pkg.sv
verilog/io_pkg.sv
verilog/addr_decoder.sv
verilog/sync_ram.sv
verilog/ms_timer.sv
verilog/read_mux.sv
verilog/aznable_bus.sv
tb/tb_aznable_bus.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module tb_aznable_bus -Mdir obj_dir
	./obj_dir/Vtb_aznable_bus

clean:
	rm -rf obj_dir
